/* ln_pkg.sv */
`default_nettype none

package ln_pkg;

    // vector geometry
    localparam int LANES = 8;
    localparam int VEC_BEATS = 8;
    localparam int BEAT_CNT_W = $clog2(VEC_BEATS);
    localparam logic [BEAT_CNT_W-1:0] LAST_BEAT = BEAT_CNT_W'(VEC_BEATS - 1);

    // divide by the element count of one vector
    localparam int MEAN_SHIFT = $clog2(LANES * VEC_BEATS);

    // input stage plus every second adder stage is registered
    localparam int TREE_LAT = ($clog2(LANES) + 1) / 2;

    localparam int LANE_W = 8;
    localparam int SQ_W = 2 * LANE_W + 1;
    localparam int ACC_W = 32;

    typedef logic signed [LANE_W-1:0] lane_t;
    typedef lane_t [LANES-1:0] beat_t;
    typedef logic signed [SQ_W-1:0] sq_t;
    typedef logic signed [ACC_W-1:0] acc_t;

endpackage

`default_nettype wire

/* ln_adder_tree.sv */
`timescale 1ns/1ps
`default_nettype none

module ln_adder_tree #(
    parameter type elem_t = ln_pkg::lane_t
) (
    input  wire                              clk,
    input  wire                              rstn,
    input  wire elem_t [ln_pkg::LANES-1:0]   in_elems,
    input  wire                              in_vld,
    output ln_pkg::acc_t                     sum,
    output logic                             sum_vld
);

    localparam int STAGES = $clog2(ln_pkg::LANES);
    localparam int EW = $bits(elem_t);

    genvar s, j;

    generate
        for (s = 0; s < STAGES; s++) begin : g_stage
            localparam int IW = EW + s;
            localparam int N = ln_pkg::LANES >> (s + 1);

            logic signed [IW-1:0] a_in [2*N];
            logic signed [IW:0]   a_out [N];
            logic                 vld;

            if (s == 0) begin : g_in
                always_ff @(posedge clk) begin
                    if (in_vld) begin
                        for (int k = 0; k < 2 * N; k++) begin
                            a_in[k] <= in_elems[k];
                        end
                    end
                end

                always_ff @(posedge clk or negedge rstn) begin
                    if (!rstn) begin
                        vld <= 1'b0;
                    end else begin
                        vld <= in_vld;
                    end
                end
            end else if (s % 2 == 0) begin : g_reg
                // pipeline cut between stage pairs
                always_ff @(posedge clk) begin
                    if (g_stage[s-1].vld) begin
                        for (int k = 0; k < 2 * N; k++) begin
                            a_in[k] <= g_stage[s-1].a_out[k];
                        end
                    end
                end

                always_ff @(posedge clk or negedge rstn) begin
                    if (!rstn) begin
                        vld <= 1'b0;
                    end else begin
                        vld <= g_stage[s-1].vld;
                    end
                end
            end else begin : g_comb
                assign a_in = g_stage[s-1].a_out;
                assign vld = g_stage[s-1].vld;
            end

            // one bit of growth per pairwise add
            for (j = 0; j < N; j++) begin : g_add
                assign a_out[j] = a_in[2*j] + a_in[2*j+1];
            end
        end
    endgenerate

    assign sum = ln_pkg::acc_t'(g_stage[STAGES-1].a_out[0]);
    assign sum_vld = g_stage[STAGES-1].vld;

endmodule

`default_nettype wire

/* ln_beat_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module ln_beat_fifo (
    input  wire                clk,
    input  wire                rstn,
    input  wire                wr_en,
    input  wire ln_pkg::beat_t wr_data,
    input  wire                rd_en,
    output ln_pkg::beat_t      rd_data
);

    // one vector deep, so the pointers wrap on their own
    ln_pkg::beat_t mem [ln_pkg::VEC_BEATS];

    logic [ln_pkg::BEAT_CNT_W-1:0] wr_ptr;
    logic [ln_pkg::BEAT_CNT_W-1:0] rd_ptr;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            wr_ptr <= '0;
        end else if (wr_en) begin
            wr_ptr <= wr_ptr + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            rd_ptr <= '0;
        end else if (rd_en) begin
            rd_ptr <= rd_ptr + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    // registered read port
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_ptr];
        end
    end

endmodule

`default_nettype wire

/* ln_mean_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module ln_mean_unit (
    input  wire                clk,
    input  wire                rstn,
    input  wire ln_pkg::beat_t in_data,
    input  wire                in_vld,
    output ln_pkg::lane_t      mean,
    output logic               mean_vld
);

    ln_pkg::acc_t beat_sum;
    logic         beat_sum_vld;

    ln_pkg::acc_t sum_acc;
    logic [ln_pkg::BEAT_CNT_W-1:0] sum_cnt;
    logic         sum_done;

    ln_adder_tree #(
        .elem_t(ln_pkg::lane_t)
    ) u_tree (
        .clk     (clk),
        .rstn    (rstn),
        .in_elems(in_data),
        .in_vld  (in_vld),
        .sum     (beat_sum),
        .sum_vld (beat_sum_vld)
    );

    // accumulate beat sums, flag the vector once the last one is in
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            sum_acc <= '0;
            sum_cnt <= '0;
            sum_done <= 1'b0;
            mean_vld <= 1'b0;
        end else begin
            sum_done <= beat_sum_vld && (sum_cnt == ln_pkg::LAST_BEAT);
            mean_vld <= sum_done;
            if (sum_done) begin
                sum_acc <= '0;
                sum_cnt <= '0;
            end else if (beat_sum_vld) begin
                sum_acc <= sum_acc + beat_sum;
                sum_cnt <= sum_cnt + 1'b1;
            end
        end
    end

    // floor division by the element count
    always_ff @(posedge clk) begin
        if (sum_done) begin
            mean <= ln_pkg::lane_t'(sum_acc >>> ln_pkg::MEAN_SHIFT);
        end
    end

endmodule

`default_nettype wire

/* ln_center_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module ln_center_unit (
    input  wire                clk,
    input  wire                rstn,
    input  wire ln_pkg::lane_t mean,
    input  wire                mean_vld,
    output logic               fifo_rd_en,
    input  wire ln_pkg::beat_t fifo_rd_data,
    output ln_pkg::beat_t      out_data,
    output logic               out_vld,
    output logic               out_last,
    output ln_pkg::acc_t       var_sum,
    output logic               var_vld
);

    ln_pkg::lane_t mean_q;

    logic                          draining;
    logic [ln_pkg::BEAT_CNT_W-1:0] drain_cnt;
    logic                          rd_vld;
    logic                          rd_last;

    ln_pkg::beat_t                  centered;
    ln_pkg::sq_t [ln_pkg::LANES-1:0] sq_beat;

    ln_pkg::acc_t                  sq_sum;
    logic                          sq_sum_vld;
    ln_pkg::acc_t                  var_acc;
    logic [ln_pkg::BEAT_CNT_W-1:0] sq_cnt;
    logic                          var_done;

    // x - mean, clamped to the lane range
    function automatic ln_pkg::lane_t center_lane(input ln_pkg::lane_t x,
                                                  input ln_pkg::lane_t m);
        logic signed [ln_pkg::LANE_W:0] diff;
        diff = x - m;
        if (diff > 127) begin
            return ln_pkg::lane_t'(127);
        end else if (diff < -128) begin
            return ln_pkg::lane_t'(-128);
        end
        return ln_pkg::lane_t'(diff);
    endfunction

    always_ff @(posedge clk) begin
        if (mean_vld) begin
            mean_q <= mean;
        end
    end

    // drain control, one read per cycle for a whole vector
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            draining <= 1'b0;
            drain_cnt <= '0;
        end else if (mean_vld) begin
            draining <= 1'b1;
            drain_cnt <= '0;
        end else if (draining) begin
            drain_cnt <= drain_cnt + 1'b1;
            if (drain_cnt == ln_pkg::LAST_BEAT) begin
                draining <= 1'b0;
            end
        end
    end

    assign fifo_rd_en = draining;

    // tracks the fifo output register
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            rd_vld <= 1'b0;
            rd_last <= 1'b0;
            out_vld <= 1'b0;
            out_last <= 1'b0;
        end else begin
            rd_vld <= draining;
            rd_last <= draining && (drain_cnt == ln_pkg::LAST_BEAT);
            out_vld <= rd_vld;
            out_last <= rd_last;
        end
    end

    always_comb begin
        for (int i = 0; i < ln_pkg::LANES; i++) begin
            centered[i] = center_lane(fifo_rd_data[i], mean_q);
        end
    end

    always_ff @(posedge clk) begin
        if (rd_vld) begin
            out_data <= centered;
        end
    end

    // squares of the registered centered beat
    always_comb begin
        for (int i = 0; i < ln_pkg::LANES; i++) begin
            sq_beat[i] = out_data[i] * out_data[i];
        end
    end

    ln_adder_tree #(
        .elem_t(ln_pkg::sq_t)
    ) u_sq_tree (
        .clk     (clk),
        .rstn    (rstn),
        .in_elems(sq_beat),
        .in_vld  (out_vld),
        .sum     (sq_sum),
        .sum_vld (sq_sum_vld)
    );

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            var_acc <= '0;
            sq_cnt <= '0;
            var_done <= 1'b0;
            var_vld <= 1'b0;
        end else begin
            var_done <= sq_sum_vld && (sq_cnt == ln_pkg::LAST_BEAT);
            var_vld <= var_done;
            if (var_done) begin
                var_acc <= '0;
                sq_cnt <= '0;
            end else if (sq_sum_vld) begin
                var_acc <= var_acc + sq_sum;
                sq_cnt <= sq_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (var_done) begin
            var_sum <= var_acc >>> ln_pkg::MEAN_SHIFT;
        end
    end

endmodule

`default_nettype wire

/* ln_stats_top.sv */
`timescale 1ns/1ps
`default_nettype none

module ln_stats_top (
    input  wire                clk,
    input  wire                rstn,
    input  wire ln_pkg::beat_t in_data,
    input  wire                in_vld,
    output ln_pkg::lane_t      mean,
    output logic               mean_vld,
    output ln_pkg::beat_t      out_data,
    output logic               out_vld,
    output logic               out_last,
    output ln_pkg::acc_t       var_sum,
    output logic               var_vld
);

    logic          fifo_rd_en;
    ln_pkg::beat_t fifo_rd_data;

    ln_mean_unit u_mean (
        .clk     (clk),
        .rstn    (rstn),
        .in_data (in_data),
        .in_vld  (in_vld),
        .mean    (mean),
        .mean_vld(mean_vld)
    );

    // holds the vector until the mean is known
    ln_beat_fifo u_fifo (
        .clk    (clk),
        .rstn   (rstn),
        .wr_en  (in_vld),
        .wr_data(in_data),
        .rd_en  (fifo_rd_en),
        .rd_data(fifo_rd_data)
    );

    ln_center_unit u_center (
        .clk         (clk),
        .rstn        (rstn),
        .mean        (mean),
        .mean_vld    (mean_vld),
        .fifo_rd_en  (fifo_rd_en),
        .fifo_rd_data(fifo_rd_data),
        .out_data    (out_data),
        .out_vld     (out_vld),
        .out_last    (out_last),
        .var_sum     (var_sum),
        .var_vld     (var_vld)
    );

endmodule

`default_nettype wire

/* tb_clk_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
    parameter real PERIOD_NS = 8.0
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD_NS / 2.0) clk = ~clk;
        end
    end

endmodule

`default_nettype wire

/* tb_ln_stats.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_ln_stats;

    localparam int NUM_VEC = 32;
    localparam int IDLE_CYCLES = 12;
    localparam int N_ELEMS = ln_pkg::LANES * ln_pkg::VEC_BEATS;
    localparam int WATCH_CYCLES = NUM_VEC * (4 * ln_pkg::VEC_BEATS + 20) + IDLE_CYCLES + 20;

    logic          clk;
    logic          rstn;
    ln_pkg::beat_t in_data;
    logic          in_vld;
    ln_pkg::lane_t mean;
    logic          mean_vld;
    ln_pkg::beat_t out_data;
    logic          out_vld;
    logic          out_last;
    ln_pkg::acc_t  var_sum;
    logic          var_vld;

    logic [31:0] lfsr = 32'h6d6637e0;

    ln_pkg::lane_t exp_mean_q [$];
    ln_pkg::beat_t exp_beat_q [$];
    ln_pkg::acc_t  exp_var_q [$];

    int   sent = 0;
    int   vectors_done = 0;
    int   beat_idx = 0;
    logic streaming = 1'b0;
    logic last_seen = 1'b0;

    tb_clk_gen #(.PERIOD_NS(8.0)) u_clk (.clk(clk));

    ln_stats_top UUT (
        .clk     (clk),
        .rstn    (rstn),
        .in_data (in_data),
        .in_vld  (in_vld),
        .mean    (mean),
        .mean_vld(mean_vld),
        .out_data(out_data),
        .out_vld (out_vld),
        .out_last(out_last),
        .var_sum (var_sum),
        .var_vld (var_vld)
    );

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end
        return s >> 1;
    endfunction

    task automatic get_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int k = 0; k < n; k++) begin
            lfsr = lfsr_next(lfsr);
            v = {v[30:0], lfsr[0]};
        end
    endtask

    // floor mean, clamped centering, floor of the mean square
    function automatic void ref_model(input ln_pkg::beat_t vec [ln_pkg::VEC_BEATS],
                                      output ln_pkg::lane_t m,
                                      output ln_pkg::beat_t cen [ln_pkg::VEC_BEATS],
                                      output ln_pkg::acc_t v);
        int sum;
        int sq_sum;
        int q;
        int d;
        sum = 0;
        sq_sum = 0;
        for (int b = 0; b < ln_pkg::VEC_BEATS; b++) begin
            for (int i = 0; i < ln_pkg::LANES; i++) begin
                sum += int'(vec[b][i]);
            end
        end
        q = sum / N_ELEMS;
        if (sum < 0 && q * N_ELEMS != sum) begin
            q = q - 1;
        end
        m = ln_pkg::lane_t'(q);
        for (int b = 0; b < ln_pkg::VEC_BEATS; b++) begin
            for (int i = 0; i < ln_pkg::LANES; i++) begin
                d = int'(vec[b][i]) - int'(m);
                d = (d > 127) ? 127 : ((d < -128) ? -128 : d);
                cen[b][i] = ln_pkg::lane_t'(d);
                sq_sum += d * d;
            end
        end
        v = ln_pkg::acc_t'(sq_sum / N_ELEMS);
    endfunction

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("Regression failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_lane(input string name, input ln_pkg::lane_t exp,
                              input ln_pkg::lane_t act);
        if (act !== exp) begin
            fail_now($sformatf("[FAIL] %s expected %h got %h", name, exp, act));
        end
    endtask

    task automatic check_beat(input string name, input ln_pkg::beat_t exp,
                              input ln_pkg::beat_t act);
        if (act !== exp) begin
            fail_now($sformatf("[FAIL] %s expected %h got %h", name, exp, act));
        end
    endtask

    task automatic check_acc(input string name, input ln_pkg::acc_t exp,
                             input ln_pkg::acc_t act);
        if (act !== exp) begin
            fail_now($sformatf("[FAIL] %s expected %h got %h", name, exp, act));
        end
    endtask

    // kind 0 random, kind 1 mostly -128, kind 2 mostly 127
    task automatic send_vector(input int kind, input bit gaps);
        ln_pkg::beat_t vec [ln_pkg::VEC_BEATS];
        ln_pkg::beat_t cen [ln_pkg::VEC_BEATS];
        ln_pkg::lane_t m;
        ln_pkg::acc_t  v;
        logic [31:0]   bits;
        logic          minor;
        for (int b = 0; b < ln_pkg::VEC_BEATS; b++) begin
            for (int i = 0; i < ln_pkg::LANES; i++) begin
                if (kind == 0) begin
                    get_bits(8, bits);
                    vec[b][i] = ln_pkg::lane_t'(bits[7:0]);
                end else begin
                    get_bits(3, bits);
                    minor = (bits[2:0] == 3'd0) || (b == 0 && i == 0);
                    vec[b][i] = ((kind == 1) ^ minor) ? ln_pkg::lane_t'(-128)
                                                      : ln_pkg::lane_t'(127);
                end
            end
        end
        ref_model(vec, m, cen, v);
        exp_mean_q.push_back(m);
        for (int b = 0; b < ln_pkg::VEC_BEATS; b++) begin
            exp_beat_q.push_back(cen[b]);
        end
        exp_var_q.push_back(v);
        sent++;
        for (int b = 0; b < ln_pkg::VEC_BEATS; b++) begin
            if (gaps) begin
                get_bits(1, bits);
                if (bits[0]) begin
                    @(posedge clk);
                    in_vld <= 1'b0;
                end
            end
            @(posedge clk);
            in_data <= vec[b];
            in_vld <= 1'b1;
        end
        @(posedge clk);
        in_vld <= 1'b0;
        wait (vectors_done == sent);
    endtask

    // outputs are sampled mid-cycle
    always @(negedge clk) begin
        if (rstn) begin
            if (var_vld) begin
                if (!last_seen || exp_var_q.size() == 0) begin
                    fail_now("var_vld pulsed without a finished centered vector");
                end else begin
                    check_acc("var_sum", exp_var_q.pop_front(), var_sum);
                    last_seen = 1'b0;
                    vectors_done++;
                end
            end
            if (mean_vld) begin
                if (exp_mean_q.size() == 0) begin
                    fail_now("mean_vld pulsed with no vector pending");
                end else begin
                    check_lane("mean", exp_mean_q.pop_front(), mean);
                end
            end
            if (out_vld) begin
                if (exp_beat_q.size() == 0) begin
                    fail_now("out_vld high with no centered beat expected");
                end else if (out_last !== (beat_idx == ln_pkg::VEC_BEATS - 1)) begin
                    fail_now($sformatf("[FAIL] out_last expected %h got %h",
                                       beat_idx == ln_pkg::VEC_BEATS - 1, out_last));
                end else begin
                    check_beat($sformatf("out_data[%0d]", beat_idx),
                               exp_beat_q.pop_front(), out_data);
                    streaming = !out_last;
                    last_seen = out_last;
                    beat_idx = out_last ? 0 : beat_idx + 1;
                end
            end else if (streaming || out_last) begin
                fail_now("centered beats broke off before the last beat of a vector");
            end
        end
    end

    initial begin
        repeat (WATCH_CYCLES) @(posedge clk);
        fail_now("outputs stopped arriving before all vectors were processed");
    end

    initial begin
        rstn = 1'b0;
        in_vld = 1'b0;
        in_data = '0;
        repeat (5) @(posedge clk);
        rstn <= 1'b1;
        // quiet window, any valid here is an error
        repeat (IDLE_CYCLES) @(posedge clk);
        for (int n = 0; n < 4; n++) begin
            send_vector(0, 1'b0);
        end
        for (int n = 0; n < 4; n++) begin
            send_vector(0, 1'b1);
        end
        for (int n = 0; n < 2; n++) begin
            send_vector(1, 1'b0);
            send_vector(2, 1'b0);
        end
        for (int n = 0; n < 20; n++) begin
            send_vector(0, 1'b0);
        end
        repeat (10) @(posedge clk);
        if (exp_mean_q.size() != 0 || exp_beat_q.size() != 0 || exp_var_q.size() != 0) begin
            fail_now("some expected results never appeared at the outputs");
        end else begin
            $display("Regression passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* sources.f */
ln_pkg.sv
ln_adder_tree.sv
ln_beat_fifo.sv
ln_mean_unit.sv
ln_center_unit.sv
ln_stats_top.sv
tb_clk_gen.sv
tb_ln_stats.sv

/* Bender.yml */
package:
  name: ln_stats

sources:
  - ln_pkg.sv
  - ln_adder_tree.sv
  - ln_beat_fifo.sv
  - ln_mean_unit.sv
  - ln_center_unit.sv
  - ln_stats_top.sv
  - target: test
    files:
      - tb_clk_gen.sv
      - tb_ln_stats.sv
